// File: chan_io_top.f
verilog/io_bus_pkg.sv
verilog/chan_reg_pkg.sv
verilog/io_slot_decode.sv
verilog/chan_io_block.sv
verilog/io_read_merge.sv
verilog/chan_io_top.sv
sim/chan_io_checker.sv
sim/chan_io_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and fails when the log reports a failure
set -e
set -o pipefail
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 --timescale 1ns/1ps \
  --top-module chan_io_tb -f chan_io_top.f -o chan_io_sim

./obj_dir/chan_io_sim 2>&1 | tee "$LOG"

if grep -qF '** FAIL **' "$LOG"; then
  echo "simulation failed, see $LOG"
  exit 1
fi
echo "simulation passed"

// File: sim/chan_io_tb.sv
// testbench top: clock, reset, host bus stimulus from an LCG, DUT and checker side by side
module chan_io_tb import io_bus_pkg::*, chan_reg_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_OPS       = 300;
  localparam int TIMEOUT_CYC = 6 * N_OPS + 50;      // reset fits in the margin
  localparam int ST_BITS     = STATUS_W * NUM_CHAN; // all status pins together

  logic                           io_clk;
  logic                           rst;
  logic                           io_sync;
  logic                           io_rd_en;
  logic                           io_wr_en;
  logic [ADDR_W-1:0]              io_addr;
  logic [DATA_W-1:0]              io_wr_data;
  logic [DATA_W-1:0]              io_rd_data;
  logic                           io_rd_ack;
  logic [NUM_CHAN-1:0]            channel_up, lane_up, pll_not_locked;
  logic [NUM_CHAN-1:0]            frame_err, hard_err, soft_err;
  logic [NUM_CHAN-1:0]            tx_resetdone_out, rx_resetdone_out, link_reset_out;
  logic [NUM_CHAN*LOOPBACK_W-1:0] loopback_set;
  int                             err_count;   // kept by the checker
  int                             cycles = 0;
  int                             op_count = 0;
  logic [31:0]                    seed = 32'h7bd1696b;

  chan_io_top u_dut (.*);
  chan_io_checker u_chk (.*);

  initial begin
    io_clk = 1'b0;
    forever #50 io_clk = ~io_clk;   // 100 ns period
  end

  always @(posedge io_clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT_CYC) begin
      $display("timeout: run hung, not finished after %0d cycles", TIMEOUT_CYC);
      $display("** FAIL **");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(output logic [31:0] v);
    seed = lcg_step(seed);
    v    = seed;
  endtask

  task automatic shuffle_status();
    logic [31:0] a;
    logic [31:0] b;
    draw(a);
    draw(b);
    {link_reset_out, rx_resetdone_out, tx_resetdone_out, pll_not_locked, soft_err, hard_err,
     frame_err, lane_up, channel_up} = ST_BITS'({b, a});
  endtask

  // one host access, status held from two cycles before the strobe
  task automatic bus_op(input logic wr, input logic [SLOT_W-1:0] slot,
                        input logic [REG_OFS_W-1:0] ofs, input logic [DATA_W-1:0] wdata);
    logic [31:0] r;
    int          waited;
    shuffle_status();
    draw(r);
    repeat (2) @(negedge io_clk);
    io_sync    = 1'b1;
    io_rd_en   = ~wr;
    io_wr_en   = wr;
    io_addr    = {slot, r[SLOT_LSB-1:REG_OFS_W], ofs};  // middle bits ignored by the DUT
    io_wr_data = wdata;
    @(negedge io_clk);
    io_sync    = 1'b0;
    io_rd_en   = 1'b0;
    io_wr_en   = 1'b0;
    io_wr_data = r;   // junk, decoder already holds its copy
    op_count++;
    if ((slot - CHAN_BASE_SLOT) >= SLOT_W'(NUM_CHAN)) begin
      repeat (5) @(negedge io_clk);   // empty slot, checker flags any ack
    end else if (wr) begin
      @(negedge io_clk);
    end else begin
      waited = 0;
      while (io_rd_ack !== 1'b1 && waited < 8) begin
        @(negedge io_clk);
        waited++;
      end
    end
  endtask

  initial begin
    logic [31:0]          r;
    logic [31:0]          d;
    logic [SLOT_W-1:0]    slot;
    logic [REG_OFS_W-1:0] ofs;
    rst        = 1'b1;
    io_sync    = 1'b0;
    io_rd_en   = 1'b0;
    io_wr_en   = 1'b0;
    io_addr    = '0;
    io_wr_data = '0;
    shuffle_status();
    repeat (10) @(negedge io_clk);
    rst = 1'b0;
    ////////////////////
    // directed
    ////////////////////
    for (int i = 0; i < NUM_CHAN; i++) begin   // loopback after reset
      bus_op(1'b0, CHAN_BASE_SLOT + SLOT_W'(i), OFS_LOOPBACK, '0);
    end
    for (int i = 0; i < NUM_CHAN; i++) begin
      draw(d);
      bus_op(1'b1, CHAN_BASE_SLOT + SLOT_W'(i), OFS_LOOPBACK, d);
      bus_op(1'b0, CHAN_BASE_SLOT + SLOT_W'(i), OFS_LOOPBACK, '0);
      bus_op(1'b0, CHAN_BASE_SLOT + SLOT_W'(i), OFS_LIVE_STATUS, '0);
    end
    for (int o = 2; o < 16; o++) begin         // unused offsets
      bus_op(1'b0, CHAN_BASE_SLOT + SLOT_W'(o % int'(NUM_CHAN)), REG_OFS_W'(o), '0);
    end
    draw(d);
    bus_op(1'b1, CHAN_BASE_SLOT - SLOT_W'(1), OFS_LOOPBACK, d);
    bus_op(1'b1, CHAN_BASE_SLOT + SLOT_W'(NUM_CHAN), OFS_LOOPBACK, d);
    bus_op(1'b0, CHAN_BASE_SLOT - SLOT_W'(1), OFS_LOOPBACK, '0);
    bus_op(1'b0, CHAN_BASE_SLOT + SLOT_W'(NUM_CHAN), OFS_LIVE_STATUS, '0);
    bus_op(1'b0, '0, OFS_LOOPBACK, '0);
    bus_op(1'b1, '1, OFS_LOOPBACK, d);
    ////////////////////
    // random mix
    ////////////////////
    while (op_count < N_OPS) begin
      draw(r);
      draw(d);
      slot = CHAN_BASE_SLOT + SLOT_W'(int'(r[15:8]) % int'(NUM_CHAN));
      if (r[4:0] >= 5'd28) begin
        slot = CHAN_BASE_SLOT + SLOT_W'(NUM_CHAN) + SLOT_W'(r[7:5]);   // a few empty slots
      end
      ofs = r[16] ? OFS_LOOPBACK : (r[17] ? OFS_LIVE_STATUS : r[21:18]);
      bus_op(r[22], slot, ofs, d);
    end
    repeat (4) @(negedge io_clk);
    $display("done: %0d operations, %0d errors", op_count, err_count);
    if (err_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: sim/chan_io_checker.sv
// testbench checker: models the channel registers, compares the DUT ports each cycle, counts errors
module chan_io_checker import io_bus_pkg::*, chan_reg_pkg::*; (
  input  logic                           io_clk,
  input  logic                           rst,
  input  logic                           io_sync,
  input  logic                           io_rd_en,
  input  logic                           io_wr_en,
  input  logic [ADDR_W-1:0]              io_addr,
  input  logic [DATA_W-1:0]              io_wr_data,
  input  logic [DATA_W-1:0]              io_rd_data,
  input  logic                           io_rd_ack,
  input  logic [NUM_CHAN-1:0]            channel_up,
  input  logic [NUM_CHAN-1:0]            lane_up,
  input  logic [NUM_CHAN-1:0]            frame_err,
  input  logic [NUM_CHAN-1:0]            hard_err,
  input  logic [NUM_CHAN-1:0]            soft_err,
  input  logic [NUM_CHAN-1:0]            pll_not_locked,
  input  logic [NUM_CHAN-1:0]            tx_resetdone_out,
  input  logic [NUM_CHAN-1:0]            rx_resetdone_out,
  input  logic [NUM_CHAN-1:0]            link_reset_out,
  input  logic [NUM_CHAN*LOOPBACK_W-1:0] loopback_set,
  output int                             err_count
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [DATA_W-1:0]              lb_model [NUM_CHAN];  // loopback words as the bus wrote them
  logic [NUM_CHAN*LOOPBACK_W-1:0] exp_set;
  logic [STATUS_W-1:0]            status;    // addressed channel's pins at edge 0
  logic [SLOT_W-1:0]              rel;       // slot relative to channel 0
  logic [DATA_W-1:0]              lb_new;
  logic [DATA_W-1:0]              rd_word;
  logic [DATA_W-1:0]              rd_exp;    // predicted word of the pending read
  logic [DATA_W-1:0]              wr_word;
  logic                           rd_pend;
  logic                           wr_pend;
  int                             cyc;
  int                             rd_due;
  int                             wr_due;
  int                             wr_ch;
  int                             ch;

  // one access against one channel's register map, returns the read word
  function automatic logic [DATA_W-1:0] ref_access(
    input  logic                 wr,
    input  logic [REG_OFS_W-1:0] ofs,
    input  logic [DATA_W-1:0]    wdata,
    input  logic [STATUS_W-1:0]  st,
    input  logic [DATA_W-1:0]    lb_cur,
    output logic [DATA_W-1:0]    lb_next
  );
    logic [DATA_W-1:0] rdata;
    rdata   = '0;   // unused offsets read as zero
    lb_next = lb_cur;
    if (wr && ofs == OFS_LOOPBACK) begin
      lb_next = wdata;                          // full word kept
    end else if (!wr && ofs == OFS_LIVE_STATUS) begin
      rdata = {{(DATA_W-STATUS_W){1'b0}}, st};  // upper bits zero
    end else if (!wr && ofs == OFS_LOOPBACK) begin
      rdata = lb_cur;
    end
    return rdata;
  endfunction

  always @(posedge io_clk) begin
    if (rst) begin
      cyc     = 0;
      rd_pend = 1'b0;
      wr_pend = 1'b0;
      for (int i = 0; i < NUM_CHAN; i++) begin
        lb_model[i] = DATA_W'(LOOPBACK_RST);
      end
    end else begin
      cyc++;
      if (wr_pend && cyc == wr_due) begin   // write visible after edge 2
        lb_model[wr_ch] = wr_word;
        wr_pend         = 1'b0;
      end
      for (int i = 0; i < NUM_CHAN; i++) begin
        exp_set[i*LOOPBACK_W +: LOOPBACK_W] = lb_model[i][LOOPBACK_W-1:0];
      end
      if (loopback_set !== exp_set) begin
        $display("CHECK FAILED loopback_set: got %h, expected %h at cycle %0d",
                 loopback_set, exp_set, cyc);
        err_count++;
      end
      ////////////////////
      // read acknowledge
      ////////////////////
      if (io_rd_ack !== 1'b0) begin
        if (rd_pend && cyc == rd_due) begin
          if (io_rd_data !== rd_exp) begin
            $display("CHECK FAILED io_rd_data: got %h, expected %h at cycle %0d",
                     io_rd_data, rd_exp, cyc);
            err_count++;
          end
          rd_pend = 1'b0;
        end else begin
          $display("unexpected read acknowledge at cycle %0d", cyc);
          err_count++;
        end
      end else if (rd_pend && cyc == rd_due) begin
        $display("read acknowledge missing, expected at cycle %0d", cyc);
        err_count++;
        rd_pend = 1'b0;
      end
      // edge 0 of a new operation, empty slots leave nothing pending
      if (io_sync) begin
        rel = io_addr[SLOT_LSB +: SLOT_W] - CHAN_BASE_SLOT;
        if (rel < SLOT_W'(NUM_CHAN)) begin
          ch      = int'(rel);
          status  = {link_reset_out[ch], rx_resetdone_out[ch], tx_resetdone_out[ch],
                     pll_not_locked[ch], soft_err[ch], hard_err[ch], frame_err[ch],
                     lane_up[ch], channel_up[ch]};
          rd_word = ref_access(io_wr_en, io_addr[REG_OFS_W-1:0], io_wr_data, status,
                               lb_model[ch], lb_new);
          if (io_wr_en) begin
            wr_pend = 1'b1;
            wr_due  = cyc + 3;
            wr_ch   = ch;
            wr_word = lb_new;
          end else if (io_rd_en) begin
            rd_pend = 1'b1;
            rd_due  = cyc + 4;   // ack high after edge 3
            rd_exp  = rd_word;
          end
        end
      end
    end
  end

endmodule

// File: verilog/chan_io_top.sv
// top of the channel register subsystem, connects slot decoder, channel blocks and read merge
module chan_io_top import io_bus_pkg::*, chan_reg_pkg::*; (
  input  logic                           io_clk,
  input  logic                           rst,
  // host programming bus
  input  logic                           io_sync,
  input  logic                           io_rd_en,
  input  logic                           io_wr_en,
  input  logic [ADDR_W-1:0]              io_addr,
  input  logic [DATA_W-1:0]              io_wr_data,
  output logic [DATA_W-1:0]              io_rd_data,
  output logic                           io_rd_ack,
  // link status, one bit per channel
  input  logic [NUM_CHAN-1:0]            frame_err,
  input  logic [NUM_CHAN-1:0]            hard_err,
  input  logic [NUM_CHAN-1:0]            soft_err,
  input  logic [NUM_CHAN-1:0]            channel_up,
  input  logic [NUM_CHAN-1:0]            lane_up,
  input  logic [NUM_CHAN-1:0]            pll_not_locked,
  input  logic [NUM_CHAN-1:0]            tx_resetdone_out,
  input  logic [NUM_CHAN-1:0]            rx_resetdone_out,
  input  logic [NUM_CHAN-1:0]            link_reset_out,
  // loopback settings, channel i in field i
  output logic [NUM_CHAN*LOOPBACK_W-1:0] loopback_set
);

  logic                       dec_sync;
  logic                       dec_rd_en;
  logic                       dec_wr_en;
  logic [REG_OFS_W-1:0]       dec_ofs;
  logic [DATA_W-1:0]          dec_wr_data;
  logic [NUM_CHAN-1:0]        chan_sel;      // one-hot, or zero for an empty slot
  logic [NUM_CHAN*DATA_W-1:0] chan_rd_data;
  logic [NUM_CHAN-1:0]        chan_rd_ack;

  ////////////////////
  // address decode
  ////////////////////
  io_slot_decode u_decode (
    .io_clk      (io_clk),
    .rst         (rst),
    .io_sync     (io_sync),
    .io_rd_en    (io_rd_en),
    .io_wr_en    (io_wr_en),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .dec_sync    (dec_sync),
    .dec_rd_en   (dec_rd_en),
    .dec_wr_en   (dec_wr_en),
    .dec_ofs     (dec_ofs),
    .dec_wr_data (dec_wr_data),
    .chan_sel    (chan_sel)
  );

  ////////////////////
  // channel blocks
  ////////////////////
  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    chan_io_block u_chan (
      .io_clk           (io_clk),
      .rst              (rst),
      .dec_sync         (dec_sync),
      .dec_rd_en        (dec_rd_en),
      .dec_wr_en        (dec_wr_en),
      .dec_ofs          (dec_ofs),
      .dec_wr_data      (dec_wr_data),
      .sel              (chan_sel[i]),
      .frame_err        (frame_err[i]),
      .hard_err         (hard_err[i]),
      .soft_err         (soft_err[i]),
      .channel_up       (channel_up[i]),
      .lane_up          (lane_up[i]),
      .pll_not_locked   (pll_not_locked[i]),
      .tx_resetdone_out (tx_resetdone_out[i]),
      .rx_resetdone_out (rx_resetdone_out[i]),
      .link_reset_out   (link_reset_out[i]),
      .rd_data          (chan_rd_data[i*DATA_W +: DATA_W]),
      .rd_ack           (chan_rd_ack[i]),
      .loopback_set     (loopback_set[i*LOOPBACK_W +: LOOPBACK_W])
    );
  end

  ////////////////////
  // read merge
  ////////////////////
  io_read_merge u_merge (
    .io_clk       (io_clk),
    .rst          (rst),
    .chan_rd_data (chan_rd_data),
    .chan_rd_ack  (chan_rd_ack),
    .io_rd_data   (io_rd_data),
    .io_rd_ack    (io_rd_ack)
  );

endmodule

// File: verilog/io_read_merge.sv
// merges the per-channel readback into one registered host read port
module io_read_merge import io_bus_pkg::*; (
  input  logic                         io_clk,
  input  logic                         rst,
  input  logic [NUM_CHAN*DATA_W-1:0]   chan_rd_data,  // channel i in slice i
  input  logic [NUM_CHAN-1:0]          chan_rd_ack,
  output logic [DATA_W-1:0]            io_rd_data,    // held between reads
  output logic                         io_rd_ack      // one pulse per read
);

  logic [DATA_W-1:0] merged;   // OR of the acknowledging channels
  logic              any_ack;

  assign any_ack = |chan_rd_ack;

  // channels that did not acknowledge contribute nothing
  always_comb begin
    merged = '0;
    for (int i = 0; i < NUM_CHAN; i++) begin
      if (chan_rd_ack[i]) begin
        merged = merged | chan_rd_data[i*DATA_W +: DATA_W];
      end
    end
  end

  always_ff @(posedge io_clk) begin
    if (rst) begin
      io_rd_ack  <= 1'b0;
      io_rd_data <= '0;
    end else begin
      io_rd_ack <= any_ack;
      if (any_ack) begin
        io_rd_data <= merged;  // only load on a real read
      end
    end
  end

endmodule

// File: verilog/chan_io_block.sv
// status and loopback registers of one link channel, read and written over the decoded bus
module chan_io_block import io_bus_pkg::*, chan_reg_pkg::*; (
  input  logic                  io_clk,
  input  logic                  rst,
  // decoded bus, registered in the decoder
  input  logic                  dec_sync,
  input  logic                  dec_rd_en,
  input  logic                  dec_wr_en,
  input  logic [REG_OFS_W-1:0]  dec_ofs,
  input  logic [DATA_W-1:0]     dec_wr_data,
  input  logic                  sel,               // this channel's chan_sel bit
  // live link status
  input  logic                  frame_err,
  input  logic                  hard_err,
  input  logic                  soft_err,
  input  logic                  channel_up,
  input  logic                  lane_up,
  input  logic                  pll_not_locked,
  input  logic                  tx_resetdone_out,
  input  logic                  rx_resetdone_out,
  input  logic                  link_reset_out,
  // readback to the merge stage
  output logic [DATA_W-1:0]     rd_data,
  output logic                  rd_ack,
  // transceiver control
  output logic [LOOPBACK_W-1:0] loopback_set
);

  logic                wr_hit;         // selected write strobe
  logic                rd_hit;         // selected read strobe
  logic [STATUS_W-1:0] status_now;     // status pins gathered in map order
  logic [DATA_W-1:0]   live_status_q;  // one cycle behind the pins
  logic [DATA_W-1:0]   loopback_q;     // full 32-bit loopback word
  logic [DATA_W-1:0]   rd_mux;         // addressed register or zero

  assign wr_hit = dec_sync & sel & dec_wr_en;
  assign rd_hit = dec_sync & sel & dec_rd_en;

  ////////////////////
  // live status
  ////////////////////
  always_comb begin
    status_now                     = '0;
    status_now[BIT_CHANNEL_UP]     = channel_up;
    status_now[BIT_LANE_UP]        = lane_up;
    status_now[BIT_FRAME_ERR]      = frame_err;
    status_now[BIT_HARD_ERR]       = hard_err;
    status_now[BIT_SOFT_ERR]       = soft_err;
    status_now[BIT_PLL_NOT_LOCKED] = pll_not_locked;
    status_now[BIT_TX_RESETDONE]   = tx_resetdone_out;
    status_now[BIT_RX_RESETDONE]   = rx_resetdone_out;
    status_now[BIT_LINK_RESET]     = link_reset_out;
  end

  // sampled every cycle, upper bits zero-extended
  always_ff @(posedge io_clk) begin
    live_status_q <= DATA_W'(status_now);
  end

  ////////////////////
  // loopback register
  ////////////////////
  always_ff @(posedge io_clk) begin
    if (rst) begin
      loopback_q <= DATA_W'(LOOPBACK_RST);
    end else if (wr_hit && dec_ofs == OFS_LOOPBACK) begin
      loopback_q <= dec_wr_data;  // whole word kept for readback
    end
  end

  assign loopback_set = loopback_q[LOOPBACK_W-1:0];  // only the low bits reach the link

  ////////////////////
  // readback
  ////////////////////
  // unused offsets in the slot read as zero
  always_comb begin
    case (dec_ofs)
      OFS_LIVE_STATUS: rd_mux = live_status_q;
      OFS_LOOPBACK:    rd_mux = loopback_q;
      default:         rd_mux = '0;
    endcase
  end

  always_ff @(posedge io_clk) begin
    if (rst) begin
      rd_ack <= 1'b0;
    end else begin
      rd_ack <= rd_hit;   // single-cycle pulse
    end
  end

  // data held between reads, the merge stage masks it by rd_ack
  always_ff @(posedge io_clk) begin
    if (rd_hit) begin
      rd_data <= rd_mux;
    end
  end

endmodule

// File: verilog/io_slot_decode.sv
// registers each host bus operation and turns its slot field into one-hot channel selects
module io_slot_decode import io_bus_pkg::*, chan_reg_pkg::*; (
  input  logic                 io_clk,
  input  logic                 rst,
  input  logic                 io_sync,      // one-cycle start strobe
  input  logic                 io_rd_en,
  input  logic                 io_wr_en,
  input  logic [ADDR_W-1:0]    io_addr,
  input  logic [DATA_W-1:0]    io_wr_data,
  output logic                 dec_sync,     // strobe, two cycles behind io_sync
  output logic                 dec_rd_en,
  output logic                 dec_wr_en,
  output logic [REG_OFS_W-1:0] dec_ofs,      // register offset inside the slot
  output logic [DATA_W-1:0]    dec_wr_data,
  output logic [NUM_CHAN-1:0]  chan_sel      // held until the next operation
);

  logic [SLOT_W-1:0]   slot;      // address bits 31:20
  logic [NUM_CHAN-1:0] slot_hit;  // combinational match per channel
  logic                sync_q;    // io_sync one cycle later

  assign slot = io_addr[SLOT_LSB +: SLOT_W];

  // compare against each channel's slot, no hit outside the channel range
  always_comb begin
    for (int i = 0; i < NUM_CHAN; i++) begin
      slot_hit[i] = (slot == CHAN_BASE_SLOT + SLOT_W'(i));
    end
  end

  // control flops
  always_ff @(posedge io_clk) begin
    if (rst) begin
      sync_q    <= 1'b0;
      dec_sync  <= 1'b0;
      dec_rd_en <= 1'b0;
      dec_wr_en <= 1'b0;
      chan_sel  <= '0;
    end else begin
      sync_q   <= io_sync;
      dec_sync <= sync_q;        // payload below is already settled by then
      if (io_sync) begin
        dec_rd_en <= io_rd_en;
        dec_wr_en <= io_wr_en;
        chan_sel  <= slot_hit;   // all zero for an empty slot
      end
    end
  end

  // payload flops, fanout to every channel starts here
  always_ff @(posedge io_clk) begin
    if (io_sync) begin
      dec_ofs     <= io_addr[REG_OFS_W-1:0];
      dec_wr_data <= io_wr_data;
    end
  end

endmodule

// File: verilog/chan_reg_pkg.sv
// register map of one channel block, offsets plus status bit layout, imported where needed
package chan_reg_pkg;

  //////////////////////
  // register offsets
  //////////////////////
  localparam int unsigned REG_OFS_W = 4;                   // address bits 3:0
  localparam logic [REG_OFS_W-1:0] OFS_LIVE_STATUS = 4'd0; // read only
  localparam logic [REG_OFS_W-1:0] OFS_LOOPBACK    = 4'd1; // read/write

  //////////////////////
  // loopback field
  //////////////////////
  localparam int unsigned LOOPBACK_W   = 3;  // width of the transceiver loopback setting
  localparam int unsigned LOOPBACK_RST = 0;  // normal operation, no loopback

  //////////////////////
  // live status bits
  //////////////////////
  localparam int unsigned STATUS_W = 9;      // bits above this read back as zero

  localparam int unsigned BIT_CHANNEL_UP     = 0;
  localparam int unsigned BIT_LANE_UP        = 1;
  localparam int unsigned BIT_FRAME_ERR      = 2;
  localparam int unsigned BIT_HARD_ERR       = 3;
  localparam int unsigned BIT_SOFT_ERR       = 4;
  localparam int unsigned BIT_PLL_NOT_LOCKED = 5;
  localparam int unsigned BIT_TX_RESETDONE   = 6;
  localparam int unsigned BIT_RX_RESETDONE   = 7;
  localparam int unsigned BIT_LINK_RESET     = 8;

endpackage

// File: verilog/io_bus_pkg.sv
// programming bus widths, slot decode constants and channel count, shared by RTL and testbench
package io_bus_pkg;

  //////////////////////
  // bus widths
  //////////////////////
  localparam int unsigned ADDR_W = 32;   // host address width
  localparam int unsigned DATA_W = 32;   // read and write data width

  //////////////////////
  // slot decoding
  //////////////////////
  // address bits 31:20 pick the slot
  localparam int unsigned SLOT_LSB = 20;
  localparam int unsigned SLOT_W   = 12;

  // channel i lives at CHAN_BASE_SLOT + i
  localparam logic [SLOT_W-1:0] CHAN_BASE_SLOT = 12'h010;

  //////////////////////
  // channel count
  //////////////////////
  localparam int unsigned NUM_CHAN = 4;  // one register block per channel

endpackage
